// File: mipsPkg.sv
//========================================
// shared definitions for the single-cycle MIPS core
// opcode and funct codes, ALU operation codes and the
// instruction word with its R, I and J views
//========================================

package mipsPkg;

  //========================================
  // register index
  //========================================
  typedef logic [4:0] regAddrT;

  //========================================
  // primary opcodes, instr[31:26]
  //========================================
  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  // funct codes, only meaningful under opRtype
  localparam logic [5:0] fnJr  = 6'h08;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ALU operations after decode
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  //========================================
  // instruction formats
  //========================================
  typedef struct packed {
    logic [5:0] opcode;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFmtT;

  typedef struct packed {
    logic [5:0]  opcode;
    regAddrT     rs;
    regAddrT     rt;
    logic [15:0] imm16;
  } iFmtT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } jFmtT;

  // one fetched word, three ways to read it
  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    jFmtT jFmt;
  } instrWordT;

endpackage

// File: alu.sv
//========================================
// 32-bit ALU of the core
// add, sub, and, or and signed slt, with a zero flag
// used by beq
//========================================

`timescale 1ns/1ns

module alu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpT op,
  output logic [31:0]    result,
  output logic           zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      mipsPkg::aluAdd: begin
        result = a + b;
      end
      mipsPkg::aluSub: begin
        result = a - b;
      end
      mipsPkg::aluAnd: begin
        result = a & b;
      end
      mipsPkg::aluOr: begin
        result = a | b;
      end
      mipsPkg::aluSlt: begin
        // 1 or 0 in bit 0 only
        result = {31'd0, lessThan};
      end
      default: begin
        result = a + b;
      end
    endcase
  end

  // high for any op, only beq looks at it
  assign zero = (result == 32'd0);

endmodule

// File: controlUnit.sv
//========================================
// main decoder of the core
// turns opcode and funct into datapath controls and the
// ALU operation in one flat table
//========================================

`timescale 1ns/1ns

module controlUnit (
  input  mipsPkg::instrWordT instr,
  output logic               regDst,
  output logic               aluSrc,
  output logic               memToReg,
  output logic               regWrite,
  output logic               memWrite,
  output logic               branch,
  output logic               jump,
  output logic               link,
  output logic               jumpReg,
  output mipsPkg::aluOpT     aluOp
);

  always_comb begin
    // defaults give a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    jumpReg  = 1'b0;
    aluOp    = mipsPkg::aluAdd;

    case (instr.rFmt.opcode)
      mipsPkg::opRtype: begin
        // rd destination for the arithmetic group
        case (instr.rFmt.funct)
          mipsPkg::fnAdd: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluAdd;
          end
          mipsPkg::fnSub: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluSub;
          end
          mipsPkg::fnAnd: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluAnd;
          end
          mipsPkg::fnOr: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluOr;
          end
          mipsPkg::fnSlt: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluSlt;
          end
          // target comes from rs and nothing is written
          mipsPkg::fnJr:   jumpReg = 1'b1;
          default: ;
        endcase
      end
      // base plus offset with the result into rt
      mipsPkg::opLw: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      // equal when rs - rt is zero
      mipsPkg::opBeq: begin
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ:   jump = 1'b1;
      // return address into r31
      mipsPkg::opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: dataMem.sv
//========================================
// data store of the core
// read without a clock, written at the rising edge;
// contents undefined until the program stores them
//========================================

`timescale 1ns/1ns

module dataMem #(
  parameter int dataAddrBits = 6
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [dataAddrBits-1:0] addr,
  input  logic [31:0]             wData,
  output logic [31:0]             rData
);

  // number of words held
  localparam int depth = 2 ** dataAddrBits;

  logic [31:0] mem [depth];

  //========================================
  // write side
  //========================================
  // sw only, already gated with run in the core
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wData;
    end
  end

  //========================================
  // read side
  //========================================
  // lw result ready in the same cycle
  assign rData = mem[addr];

endmodule

// File: instrMem.sv
//========================================
// instruction store of the core
// written word by word through the load port while halted,
// read without a clock at the current pc
//========================================

`timescale 1ns/1ns

module instrMem #(
  parameter int instrAddrBits = 6
) (
  input  logic                     clk,
  input  logic                     loadEn,
  input  logic [instrAddrBits-1:0] loadAddr,
  input  logic [31:0]              loadData,
  input  logic [31:0]              pc,
  output mipsPkg::instrWordT       instr
);

  // number of words held
  localparam int depth = 2 ** instrAddrBits;

  logic [31:0] mem [depth];

  // word index of pc, upper bits dropped so fetch wraps
  logic [instrAddrBits-1:0] fetchAddr;

  //========================================
  // load port
  //========================================
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;
    end
  end

  //========================================
  // fetch port
  //========================================
  // byte offset bits ignored
  assign fetchAddr = pc[instrAddrBits+1:2];

  // no register on the read side
  assign instr = mem[fetchAddr];

endmodule

// File: pcUnit.sv
//========================================
// program counter and next-pc choice
// jump first, then jr, then a taken beq, else pc + 4;
// holds while run is low
//========================================

`timescale 1ns/1ns

module pcUnit (
  input  logic        clk,
  input  logic        rst,
  input  logic        run,
  input  logic        branch,
  input  logic        zero,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic [15:0] imm16,
  input  logic [25:0] target26,
  input  logic [31:0] rsData,
  output logic [31:0] pc,
  output logic [31:0] pcPlus8
);

  logic [31:0] pcPlus4;
  logic [31:0] branchOff;
  logic [31:0] jumpAddr;
  logic [31:0] nextPc;

  assign pcPlus4 = pc + 32'd4;
  // return address for jal
  assign pcPlus8 = pc + 32'd8;

  // sign-extended word offset
  assign branchOff = {{14{imm16[15]}}, imm16, 2'b00};
  // stays in the current 256 MB region
  assign jumpAddr  = {pcPlus4[31:28], target26, 2'b00};

  //========================================
  // next pc
  //========================================
  always_comb begin
    if (jump) begin
      nextPc = jumpAddr;
    end else if (jumpReg) begin
      nextPc = rsData;
    end else if (branch && zero) begin
      nextPc = pcPlus4 + branchOff;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= 32'd0;
    end else if (run) begin
      pc <= nextPc;
    end
  end

  // jr may carry any register value into pc
  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pcUnit: pc not word aligned");

endmodule

// File: regFile.sv
//========================================
// 32 x 32 general purpose register file
// two reads without a clock, one write at the rising edge,
// r0 always zero
//========================================

`timescale 1ns/1ns

module regFile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  mipsPkg::regAddrT rAddr1,
  input  mipsPkg::regAddrT rAddr2,
  input  mipsPkg::regAddrT wAddr,
  input  logic [31:0]      wData,
  output logic [31:0]      rData1,
  output logic [31:0]      rData2
);

  logic [31:0] regs [32];

  //========================================
  // write port
  //========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != '0)) begin
      // writes to r0 dropped
      regs[wAddr] <= wData;
    end
  end

  //========================================
  // read ports
  //========================================
  // a write lands at the edge, so the next instruction sees it
  assign rData1 = (rAddr1 == '0) ? 32'd0 : regs[rAddr1];
  assign rData2 = (rAddr2 == '0) ? 32'd0 : regs[rAddr2];

endmodule

// File: mipsCore.sv
//========================================
// top level of the single-cycle MIPS core
// load the program with run low, then raise run;
// one instruction retires per rising edge
//========================================

`timescale 1ns/1ns

module mipsCore #(
  parameter int instrAddrBits = 6,
  parameter int dataAddrBits  = 6
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic                     loadEn,
  input  logic [instrAddrBits-1:0] loadAddr,
  input  logic [31:0]              loadData,
  output logic [31:0]              pc,
  output logic                     wbEn,
  output mipsPkg::regAddrT         wbAddr,
  output logic [31:0]              wbData,
  output logic                     memWe,
  output logic [31:0]              memAddr,
  output logic [31:0]              memWData
);

  mipsPkg::instrWordT instr;
  mipsPkg::aluOpT     aluOp;

  logic regDst;
  logic aluSrc;
  logic memToReg;
  logic regWrite;
  logic memWrite;
  logic branch;
  logic jump;
  logic link;
  logic jumpReg;

  logic [31:0] pcPlus8;
  logic [31:0] rData1;
  logic [31:0] rData2;
  logic [31:0] signExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] memRData;

  //========================================
  // fetch and decode
  //========================================
  pcUnit uPc (
    .clk(clk), .rst(rst), .run(run),
    .branch(branch), .zero(aluZero), .jump(jump), .jumpReg(jumpReg),
    .imm16(instr.iFmt.imm16), .target26(instr.jFmt.target26),
    .rsData(rData1), .pc(pc), .pcPlus8(pcPlus8)
  );

  instrMem #(.instrAddrBits(instrAddrBits)) uImem (
    .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .pc(pc), .instr(instr)
  );

  controlUnit uCtrl (
    .instr(instr), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memWrite(memWrite), .branch(branch), .jump(jump),
    .link(link), .jumpReg(jumpReg), .aluOp(aluOp)
  );

  //========================================
  // execute and memory
  //========================================
  regFile uRegs (
    .clk(clk), .rst(rst), .we(wbEn),
    .rAddr1(instr.rFmt.rs), .rAddr2(instr.rFmt.rt), .wAddr(wbAddr),
    .wData(wbData), .rData1(rData1), .rData2(rData2)
  );

  // lw/sw offset, also the beq offset inside pcUnit
  assign signExt = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
  assign aluB    = aluSrc ? signExt : rData2;

  alu uAlu (
    .a(rData1), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero)
  );

  // word address from the byte address
  dataMem #(.dataAddrBits(dataAddrBits)) uDmem (
    .clk(clk), .we(memWe), .addr(aluResult[dataAddrBits+1:2]),
    .wData(rData2), .rData(memRData)
  );

  //========================================
  // write-back and retire outputs
  //========================================
  // r31 on jal, else rd for R-type, rt for lw
  assign wbAddr = link ? mipsPkg::regAddrT'(5'd31) :
                  (regDst ? instr.rFmt.rd : instr.rFmt.rt);
  assign wbData = link ? pcPlus8 : (memToReg ? memRData : aluResult);

  // halted core writes nothing
  assign wbEn  = regWrite & run;
  assign memWe = memWrite & run;

  // full byte address for the trace
  assign memAddr  = aluResult;
  assign memWData = rData2;

endmodule

// File: mipsTb.sv
//========================================
// testbench for the single-cycle MIPS core
// reads program words and the expected retire trace
// from mipsInput.txt, loads while halted, then runs
//========================================

`timescale 1ns/1ns

module mipsTb;

  logic        clk;
  logic        rst;
  logic        run;
  logic        loadEn;
  logic [5:0]  loadAddr;
  logic [31:0] loadData;

  logic [31:0] pc;
  logic        wbEn;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;
  logic        memWe;
  logic [31:0] memAddr;
  logic [31:0] memWData;

  // parsed data file
  logic [31:0] progAddr[$];
  logic [31:0] progWord[$];
  string       traceLines[$];
  logic        parsed;

  // one expected trace line
  logic [31:0] ePc;
  logic [31:0] eWbEn;
  logic [31:0] eWbAddr;
  logic [31:0] eWbData;
  logic [31:0] eMemWe;
  logic [31:0] eMemAddr;
  logic [31:0] eMemWData;

  mipsCore dut (
    .clk(clk), .rst(rst), .run(run),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
    .memWe(memWe), .memAddr(memAddr), .memWData(memWData)
  );

  // 100 ns period
  always #50 clk = ~clk;

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s actual %h expected %h", name, actual, expected);
      $display("Test FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  //========================================
  // watchdog
  //========================================
  initial begin
    int limitNs;
    wait (parsed === 1'b1);
    // one cycle per word and per trace line, plus slack
    limitNs = 100 * (progWord.size() + traceLines.size() + 20);
    #(limitNs);
    $display("The run did not finish in time, the testbench is stuck");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  //========================================
  // main sequence
  //========================================
  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] d;

    clk      = 1'b0;
    rst      = 1'b0;
    run      = 1'b0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    parsed   = 1'b0;

    fd = $fopen("mipsInput.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file mipsInput.txt");
      $display("Test FAILED");
      $fatal(1, "missing data file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) == "P") begin
        n = $sscanf(line, "P %h %h", a, d);
        progAddr.push_back(a);
        progWord.push_back(d);
      end else if (line.len() > 0 && line.getc(0) == "E") begin
        traceLines.push_back(line);
      end
    end
    $fclose(fd);
    parsed = 1'b1;

    // reset held over two rising edges
    repeat (2) @(posedge clk);
    rst <= 1'b1;

    // program load, core halted
    for (int i = 0; i < progWord.size(); i++) begin
      @(posedge clk);
      loadEn   <= 1'b1;
      loadAddr <= progAddr[i][5:0];
      loadData <= progWord[i];
      @(negedge clk);
      compareValue("pc", pc, 32'd0);
      compareValue("wbEn", {31'd0, wbEn}, 32'd0);
      compareValue("memWe", {31'd0, memWe}, 32'd0);
    end
    @(posedge clk);
    loadEn <= 1'b0;
    run    <= 1'b1;

    // one trace line per retired instruction
    for (int i = 0; i < traceLines.size(); i++) begin
      @(negedge clk);
      n = $sscanf(traceLines[i], "E %h %h %h %h %h %h %h",
                  ePc, eWbEn, eWbAddr, eWbData, eMemWe, eMemAddr, eMemWData);
      if (n != 7) begin
        $display("Trace line %0d of the data file has too few fields", i);
        $display("Test FAILED");
        $fatal(1, "bad trace line");
      end
      compareValue("pc", pc, ePc);
      compareValue("wbEn", {31'd0, wbEn}, eWbEn);
      // write address and data only matter when a write happens
      if (eWbEn[0]) begin
        compareValue("wbAddr", {27'd0, wbAddr}, eWbAddr);
        compareValue("wbData", wbData, eWbData);
      end
      compareValue("memWe", {31'd0, memWe}, eMemWe);
      if (eMemWe[0]) begin
        compareValue("memAddr", memAddr, eMemAddr);
        compareValue("memWData", memWData, eMemWData);
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

// File: mipsInput.txt
# P word-index program-word (hex), then a mnemonic
# E pc wbEn wbAddr wbData memWe memAddr memWData (hex), one line per run cycle
P 00 0c000001 jal 0x04
P 01 03ff0820 add r1, r31, r31
P 02 00011022 sub r2, r0, r1
P 03 0041182a slt r3, r2, r1
P 04 0022202a slt r4, r1, r2
P 05 003f2825 or r5, r1, r31
P 06 00a23024 and r6, r5, r2
P 07 00210020 add r0, r1, r1
P 08 00013820 add r7, r0, r1
P 09 ac220004 sw r2, 4(r1)
P 0a 8c280004 lw r8, 4(r1)
P 0b 11020001 beq r8, r2, +1
P 0c 00214820 add r9, r1, r1 (skipped)
P 0d 10220005 beq r1, r2, +5
P 0e 0c000012 jal 0x48
P 0f 00214820 add r9, r1, r1 (skipped)
P 10 fc221234 unknown opcode
P 11 08000014 j 0x50
P 12 03e15022 sub r10, r31, r1
P 13 03e00008 jr r31
P 14 01485820 add r11, r10, r8
E 00000000 1 1f 00000008 0 00000000 00000000
E 00000004 1 01 00000010 0 00000000 00000000
E 00000008 1 02 fffffff0 0 00000000 00000000
E 0000000c 1 03 00000001 0 00000000 00000000
E 00000010 1 04 00000000 0 00000000 00000000
E 00000014 1 05 00000018 0 00000000 00000000
E 00000018 1 06 00000010 0 00000000 00000000
E 0000001c 1 00 00000020 0 00000000 00000000
E 00000020 1 07 00000010 0 00000000 00000000
E 00000024 0 00 00000000 1 00000014 fffffff0
E 00000028 1 08 fffffff0 0 00000000 00000000
E 0000002c 0 00 00000000 0 00000000 00000000
E 00000034 0 00 00000000 0 00000000 00000000
E 00000038 1 1f 00000040 0 00000000 00000000
E 00000048 1 0a 00000030 0 00000000 00000000
E 0000004c 0 00 00000000 0 00000000 00000000
E 00000040 0 00 00000000 0 00000000 00000000
E 00000044 0 00 00000000 0 00000000 00000000
E 00000050 1 0b 00000020 0 00000000 00000000

// File: compile.f
mipsPkg.sv
alu.sv
controlUnit.sv
dataMem.sv
instrMem.sv
pcUnit.sv
regFile.sv
mipsCore.sv
mipsTb.sv
